/* hw/slideshow_pkg.sv */
// Shared image geometry, timing constants and gesture encodings, imported by every slideshow block
package slideshow_pkg;

	// ========================================
	// Widths
	// ========================================

	// Frame-buffer word address
	localparam int ADDR_W = 24;
	// Image index, up to 32 images
	localparam int IMG_W = 5;
	localparam int PIX_CNT_W = 32;
	localparam int RST_CNT_W = 8;

	// ========================================
	// Image geometry (scaled for simulation)
	// ========================================

	localparam int IMG_PIXELS = 64;
	// Two 16-bit memory words per 24-bit pixel
	localparam int WORDS_PER_PIXEL = 2;
	localparam int IMG_WORDS = IMG_PIXELS * WORDS_PER_PIXEL;

	// ========================================
	// Timing in CLOCK_33 cycles
	// ========================================

	// Swipe debounce, short delay then a long lockout
	localparam int SWIPE_DELAY = 40;
	localparam int SWIPE_HOLDOFF = 100;
	// Touch-held flag for the host
	localparam int HOLD_DELAY = 1;
	localparam int HOLD_WIDTH = 20;
	localparam int HOLD_HOLDOFF = 60;
	// Loading flag stays up this long after the last pixel
	localparam int LOAD_TAIL = 50;

	// Raw gesture codes from the touch panel
	typedef enum logic [7:0] {
		raw_up       = 8'h10,
		raw_left     = 8'h14,
		raw_down     = 8'h18,
		raw_right    = 8'h1C,
		raw_zoom_in  = 8'h48,
		raw_zoom_out = 8'h49
	} raw_gesture_e;

	// Packed code, as sent back to the host
	typedef enum logic [2:0] {
		code_none     = 3'd0,
		code_up       = 3'd1,
		code_left     = 3'd2,
		code_down     = 3'd3,
		code_right    = 3'd4,
		code_zoom_in  = 3'd5,
		code_zoom_out = 3'd6
	} gesture_code_e;

endpackage

/* hw/reset_sequencer.sv */
// Startup sequencer that holds the controllers in reset and then opens the read-restart window
`timescale 1ns/1ns

module reset_sequencer (
	input  logic CLOCK_33,
	input  logic iRSTN,
	output logic ctrl_rst,
	output logic read_restart
);
	import slideshow_pkg::*;

	logic [RST_CNT_W-1:0] cnt;

	// Runs until the top bit sets, then parks there
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			cnt <= '0;
		end else if (!cnt[RST_CNT_W-1]) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Controllers stay in reset for the first half of the run
	assign ctrl_rst = !cnt[RST_CNT_W-1];

	// Read side restarts during the second quarter
	assign read_restart = (cnt[RST_CNT_W-1 -: 2] == 2'b01);

endmodule

/* hw/gesture_pulse.sv */
// Debounce unit: turns a noisy touch event into one delayed pulse and locks out repeats
`timescale 1ns/1ns

module gesture_pulse #(
	parameter int DELAY   = 40,
	parameter int WIDTH   = 1,
	parameter int HOLDOFF = 100
) (
	input  logic CLOCK_33,
	input  logic iRSTN,
	input  logic ctrl_rst,
	input  logic trigger,
	output logic pulse
);

	localparam int CNT_W = $clog2(HOLDOFF + 1);

	logic             active;
	logic [CNT_W-1:0] count;

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			active <= 1'b0;
			count  <= '0;
		end else if (ctrl_rst) begin
			active <= 1'b0;
			count  <= '0;
		end else if (!active) begin
			// Idle, wait for an event
			if (trigger)
				active <= 1'b1;
		end else if (count == CNT_W'(HOLDOFF)) begin
			// Lockout over
			active <= 1'b0;
			count  <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Pulse window inside the active period
	assign pulse = active && (count >= CNT_W'(DELAY)) && (count <= CNT_W'(DELAY + WIDTH - 1));

endmodule

/* hw/touch_front_end.sv */
// Touch panel front end: debounced swipe pulses and the packed gesture status byte for the host
`timescale 1ns/1ns

module touch_front_end (
	input  logic                       CLOCK_33,
	input  logic                       iRSTN,
	input  logic                       ctrl_rst,
	input  logic                       touch_ready,
	input  slideshow_pkg::raw_gesture_e touch_gesture,
	input  logic [9:0]                 touch_x,
	input  logic [8:0]                 touch_y,
	output logic                       swipe_west,
	output logic                       swipe_east,
	output logic [7:0]                 gesture_info
);
	import slideshow_pkg::*;

	gesture_code_e code;
	logic          touch_held;

	// ========================================
	// Debounce units
	// ========================================

	// Sliding right means the slide moves west
	gesture_pulse #(.DELAY(SWIPE_DELAY), .WIDTH(1), .HOLDOFF(SWIPE_HOLDOFF)) u_west (
		.CLOCK_33 (CLOCK_33),
		.iRSTN    (iRSTN),
		.ctrl_rst (ctrl_rst),
		.trigger  (touch_ready && (touch_gesture == raw_right)),
		.pulse    (swipe_west)
	);

	gesture_pulse #(.DELAY(SWIPE_DELAY), .WIDTH(1), .HOLDOFF(SWIPE_HOLDOFF)) u_east (
		.CLOCK_33 (CLOCK_33),
		.iRSTN    (iRSTN),
		.ctrl_rst (ctrl_rst),
		.trigger  (touch_ready && (touch_gesture == raw_left)),
		.pulse    (swipe_east)
	);

	// Any touch, stretched so the host can see it
	gesture_pulse #(.DELAY(HOLD_DELAY), .WIDTH(HOLD_WIDTH), .HOLDOFF(HOLD_HOLDOFF)) u_hold (
		.CLOCK_33 (CLOCK_33),
		.iRSTN    (iRSTN),
		.ctrl_rst (ctrl_rst),
		.trigger  (touch_ready),
		.pulse    (touch_held)
	);

	// Raw code to 3 bits, unknown codes read as none
	always_comb begin
		case (touch_gesture)
			raw_up:       code = code_up;
			raw_left:     code = code_left;
			raw_down:     code = code_down;
			raw_right:    code = code_right;
			raw_zoom_in:  code = code_zoom_in;
			raw_zoom_out: code = code_zoom_out;
			default:      code = code_none;
		endcase
	end

	// Status byte: held flag, code, coarse position
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN)
			gesture_info <= 8'h00;
		else
			gesture_info <= {touch_held, code, touch_x[9:8], touch_y[8], 1'b0};
	end

endmodule

/* hw/image_selector.sv */
// Slideshow load tracking: pixel counter, loading flag with tail delay and swipe-driven image index
`timescale 1ns/1ns

module image_selector (
	input  logic                          CLOCK_33,
	input  logic                          iRSTN,
	input  logic                          pixel_strobe,
	input  logic [7:0]                    img_num,
	input  logic                          swipe_west,
	input  logic                          swipe_east,
	output logic [slideshow_pkg::IMG_W-1:0] current_img,
	output logic                          loading
);
	import slideshow_pkg::*;

	localparam int TAIL_W = $clog2(LOAD_TAIL + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_tail,
		st_done
	} load_state_e;

	load_state_e          state;
	logic [PIX_CNT_W-1:0] pix_cnt;
	logic [PIX_CNT_W-1:0] pix_total;
	logic [TAIL_W-1:0]    tail_cnt;
	logic                 load_done;
	logic [IMG_W-1:0]     last_img;

	// ========================================
	// Pixel count and completion
	// ========================================

	assign pix_total = PIX_CNT_W'(img_num) * PIX_CNT_W'(IMG_PIXELS);
	assign load_done = (img_num != 8'd0) && (pix_cnt == pix_total);

	// Saturates at the full slideshow size
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN)
			pix_cnt <= '0;
		else if (pixel_strobe && !load_done)
			pix_cnt <= pix_cnt + 1'b1;
	end

	// Loading FSM, idle -> load -> tail -> done
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			state    <= st_idle;
			tail_cnt <= '0;
		end else begin
			case (state)
				st_idle: if (pix_cnt != '0) state <= st_load;
				st_load: if (load_done) state <= st_tail;
				st_tail: begin
					// Tail of LOAD_TAIL + 1 cycles
					if (tail_cnt == TAIL_W'(LOAD_TAIL))
						state <= st_done;
					tail_cnt <= tail_cnt + 1'b1;
				end
				default: state <= st_done;
			endcase
		end
	end

	assign loading = (state == st_load) || (state == st_tail);

	// ========================================
	// Image index
	// ========================================

	assign last_img = img_num[IMG_W-1:0] - 1'b1;

	// Swipes only count once the whole slideshow is in memory
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			current_img <= '0;
		end else if (load_done) begin
			if (swipe_east)
				current_img <= (current_img == '0) ? last_img : current_img - 1'b1;
			else if (swipe_west)
				current_img <= (current_img == last_img) ? '0 : current_img + 1'b1;
		end
	end

endmodule

/* hw/frame_address_gen.sv */
// Per-frame read address window of the displayed image and the read FIFO reload strobe
`timescale 1ns/1ns

module frame_address_gen (
	input  logic                           CLOCK_33,
	input  logic                           iRSTN,
	input  logic [slideshow_pkg::IMG_W-1:0]  current_img,
	input  logic                           end_frame,
	input  logic                           new_frame,
	input  logic                           read_restart,
	output logic [slideshow_pkg::ADDR_W-1:0] base_read_addr,
	output logic [slideshow_pkg::ADDR_W-1:0] max_read_addr,
	output logic                           read_load
);
	import slideshow_pkg::*;

	logic [ADDR_W-1:0] next_base;

	// Start of the selected image in the frame buffer
	assign next_base = ADDR_W'(current_img) * ADDR_W'(IMG_WORDS);

	// Window only moves between frames, never mid-frame
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			base_read_addr <= '0;
			max_read_addr  <= ADDR_W'(IMG_WORDS);
		end else if (end_frame) begin
			base_read_addr <= next_base;
			max_read_addr  <= next_base + ADDR_W'(IMG_WORDS);
		end
	end

	// Flush the read FIFO at each new frame and during startup
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN)
			read_load <= 1'b0;
		else
			read_load <= new_frame || read_restart;
	end

endmodule

/* hw/slideshow_ctrl.sv */
// Slideshow control top level, wiring reset, touch, image selection and read address blocks
`timescale 1ns/1ns

module slideshow_ctrl (
	input  logic                           CLOCK_33,
	input  logic                           iRSTN,
	input  logic                           pixel_strobe,
	input  logic [7:0]                     img_num,
	input  logic                           new_frame,
	input  logic                           end_frame,
	input  logic                           touch_ready,
	input  slideshow_pkg::raw_gesture_e     touch_gesture,
	input  logic [9:0]                     touch_x,
	input  logic [8:0]                     touch_y,
	output logic                           loading,
	output logic [7:0]                     gesture_info,
	output logic [slideshow_pkg::ADDR_W-1:0] base_read_addr,
	output logic [slideshow_pkg::ADDR_W-1:0] max_read_addr,
	output logic                           read_load
);
	import slideshow_pkg::*;

	logic             ctrl_rst;
	logic             read_restart;
	logic             swipe_west;
	logic             swipe_east;
	logic [IMG_W-1:0] current_img;

	// ========================================
	// Startup
	// ========================================

	reset_sequencer u_rst_seq (
		.CLOCK_33     (CLOCK_33),
		.iRSTN        (iRSTN),
		.ctrl_rst     (ctrl_rst),
		.read_restart (read_restart)
	);

	// Touch panel side
	touch_front_end u_touch (
		.CLOCK_33      (CLOCK_33),
		.iRSTN         (iRSTN),
		.ctrl_rst      (ctrl_rst),
		.touch_ready   (touch_ready),
		.touch_gesture (touch_gesture),
		.touch_x       (touch_x),
		.touch_y       (touch_y),
		.swipe_west    (swipe_west),
		.swipe_east    (swipe_east),
		.gesture_info  (gesture_info)
	);

	image_selector u_img_sel (
		.CLOCK_33     (CLOCK_33),
		.iRSTN        (iRSTN),
		.pixel_strobe (pixel_strobe),
		.img_num      (img_num),
		.swipe_west   (swipe_west),
		.swipe_east   (swipe_east),
		.current_img  (current_img),
		.loading      (loading)
	);

	// Read side of the frame buffer
	frame_address_gen u_addr_gen (
		.CLOCK_33       (CLOCK_33),
		.iRSTN          (iRSTN),
		.current_img    (current_img),
		.end_frame      (end_frame),
		.new_frame      (new_frame),
		.read_restart   (read_restart),
		.base_read_addr (base_read_addr),
		.max_read_addr  (max_read_addr),
		.read_load      (read_load)
	);

endmodule

/* verif/slideshow_props.sv */
// Concurrent assertions that bind into the selector and address blocks to check index and window
`timescale 1ns/1ns

module slideshow_props (
	input logic                             CLOCK_33,
	input logic                             iRSTN,
	input logic                             sel_en,
	input logic                             win_en,
	input logic                             load_done,
	input logic [7:0]                       img_num,
	input logic [slideshow_pkg::IMG_W-1:0]  current_img,
	input logic [slideshow_pkg::ADDR_W-1:0] base_read_addr,
	input logic [slideshow_pkg::ADDR_W-1:0] max_read_addr
);
	import slideshow_pkg::*;

	// ========================================
	// Image index
	// ========================================

	// Index stays inside the slideshow once loaded
	a_img_range: assert property (@(posedge CLOCK_33) disable iff (!iRSTN)
		(sel_en && load_done) |-> (8'(current_img) < img_num))
		else $error("current_img %0d not below img_num %0d", current_img, img_num);

	// Window is always one image wide
	a_window: assert property (@(posedge CLOCK_33) disable iff (!iRSTN)
		win_en |-> (max_read_addr == base_read_addr + ADDR_W'(IMG_WORDS)))
		else $error("max_read_addr %0h is not base %0h plus one image", max_read_addr,
			base_read_addr);

endmodule

// Selector instance with the window check disabled
bind image_selector slideshow_props u_sel_props (
	.CLOCK_33       (CLOCK_33),
	.iRSTN          (iRSTN),
	.sel_en         (1'b1),
	.win_en         (1'b0),
	.load_done      (load_done),
	.img_num        (img_num),
	.current_img    (current_img),
	.base_read_addr ('0),
	.max_read_addr  ('0)
);

// Address instance with the index check disabled
bind frame_address_gen slideshow_props u_win_props (
	.CLOCK_33       (CLOCK_33),
	.iRSTN          (iRSTN),
	.sel_en         (1'b0),
	.win_en         (1'b1),
	.load_done      (1'b0),
	.img_num        (8'd0),
	.current_img    ('0),
	.base_read_addr (base_read_addr),
	.max_read_addr  (max_read_addr)
);

/* verif/tb_slideshow.sv */
// Top-level testbench that drives the slideshow controller with seeded random stimulus against a model
`timescale 1ns/1ns

module tb_slideshow;
	import slideshow_pkg::*;

	// Well above the roughly 3000 cycles that all phases take
	localparam int MAX_CYCLES = 20000;

	logic              CLOCK_33;
	logic              iRSTN;
	logic              pixel_strobe;
	logic [7:0]        img_num;
	logic              new_frame;
	logic              end_frame;
	logic              touch_ready;
	raw_gesture_e      touch_gesture;
	logic [9:0]        touch_x;
	logic [8:0]        touch_y;
	logic              loading;
	logic [7:0]        gesture_info;
	logic [ADDR_W-1:0] base_read_addr;
	logic [ADDR_W-1:0] max_read_addr;
	logic              read_load;

	integer      seed;
	integer      errors;
	integer      cycles = 0;
	logic [31:0] rnd;
	logic [7:0]  known_raw [6] = '{8'h10, 8'h14, 8'h18, 8'h1C, 8'h48, 8'h49};

	// Model of the image count, displayed image and latched window base
	int m_imgs;
	int m_img;
	int exp_base;

	slideshow_ctrl uut (
		.CLOCK_33       (CLOCK_33),
		.iRSTN          (iRSTN),
		.pixel_strobe   (pixel_strobe),
		.img_num        (img_num),
		.new_frame      (new_frame),
		.end_frame      (end_frame),
		.touch_ready    (touch_ready),
		.touch_gesture  (touch_gesture),
		.touch_x        (touch_x),
		.touch_y        (touch_y),
		.loading        (loading),
		.gesture_info   (gesture_info),
		.base_read_addr (base_read_addr),
		.max_read_addr  (max_read_addr),
		.read_load      (read_load)
	);

	// ========================================
	// Clock and run limit
	// ========================================

	initial begin
		CLOCK_33 = 1'b0;
		forever #2 CLOCK_33 = ~CLOCK_33;
	end

	always @(posedge CLOCK_33) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	// Inputs change and outputs are read 1 ns after the edge
	task automatic next_cycle();
		@(posedge CLOCK_33);
		#1;
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] want);
		assert (got == want) else begin
			errors = errors + 1;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	// Host code for a raw panel code with 0 for unknown codes
	function automatic logic [2:0] packed_code(input logic [7:0] raw);
		case (raw)
			8'h10:   return 3'd1;
			8'h14:   return 3'd2;
			8'h18:   return 3'd3;
			8'h1C:   return 3'd4;
			8'h48:   return 3'd5;
			8'h49:   return 3'd6;
			default: return 3'd0;
		endcase
	endfunction

	// End of frame pulse and the window compared two edges later
	task automatic end_frame_and_compare();
		end_frame = 1'b1;
		exp_base = m_img * IMG_WORDS;
		next_cycle();
		end_frame = 1'b0;
		next_cycle();
		check_eq("base_read_addr", 32'(base_read_addr), exp_base);
		check_eq("max_read_addr", 32'(max_read_addr), exp_base + IMG_WORDS);
	endtask

	// ========================================
	// Test phases
	// ========================================

	// read_load is high for counter values 64..127 plus one register stage
	task automatic startup_sequence();
		int k;
		repeat (4) @(posedge CLOCK_33);
		#1;
		iRSTN = 1'b1;
		for (k = 1; k <= 140; k++) begin
			next_cycle();
			check_eq("loading", 32'(loading), 0);
			check_eq("gesture_info", 32'(gesture_info), 0);
			check_eq("base_read_addr", 32'(base_read_addr), 0);
			check_eq("max_read_addr", 32'(max_read_addr), IMG_WORDS);
			check_eq("read_load", 32'(read_load), (k >= 65 && k <= 128) ? 1 : 0);
		end
	endtask

	// Swipe with nothing loaded must be dropped
	task automatic early_swipe();
		touch_gesture = raw_right;
		touch_ready = 1'b1;
		next_cycle();
		touch_ready = 1'b0;
		repeat (110) next_cycle();
		end_frame_and_compare();
	endtask

	task automatic load_slideshow();
		int  m_pix;
		int  prev_pix;
		int  total;
		int  k;
		bit  fell;
		total = m_imgs * IMG_PIXELS;
		m_pix = 0;
		prev_pix = 0;
		while (m_pix < total) begin
			rnd = $random(seed);
			pixel_strobe = rnd[0];
			if (pixel_strobe)
				m_pix = m_pix + 1;
			next_cycle();
			// Flag follows a non-zero count by one edge
			check_eq("loading", 32'(loading), (prev_pix != 0) ? 1 : 0);
			prev_pix = m_pix;
		end
		// Extra strobes keep coming through the tail
		fell = 1'b0;
		for (k = 1; k <= LOAD_TAIL + 3 && !fell; k++) begin
			rnd = $random(seed);
			pixel_strobe = rnd[0];
			next_cycle();
			fell = !loading;
			// Flag holds for the whole tail
			if (k <= LOAD_TAIL)
				check_eq("loading in tail", 32'(loading), 1);
		end
		assert (fell) else begin
			errors = errors + 1;
			$display("loading still high %0d cycles after the last pixel", LOAD_TAIL + 3);
		end
		for (k = 0; k < 40; k++) begin
			rnd = $random(seed);
			pixel_strobe = rnd[0];
			next_cycle();
			check_eq("loading after load", 32'(loading), 0);
		end
		pixel_strobe = 1'b0;
	endtask

	// Random frame strobes with the image held still
	task automatic random_frames();
		int k;
		for (k = 0; k < 300; k++) begin
			rnd = $random(seed);
			new_frame = rnd[0];
			end_frame = (rnd[3:1] == 3'b000);
			if (end_frame)
				exp_base = m_img * IMG_WORDS;
			next_cycle();
			check_eq("read_load", 32'(read_load), 32'(new_frame));
			check_eq("base_read_addr", 32'(base_read_addr), exp_base);
			check_eq("max_read_addr", 32'(max_read_addr), exp_base + IMG_WORDS);
		end
		new_frame = 1'b0;
		end_frame = 1'b0;
	endtask

	// One swipe plus a repeat inside the lockout
	task automatic swipe_with_repeat(input bit west);
		int gap;
		int k;
		touch_gesture = west ? raw_right : raw_left;
		touch_ready = 1'b1;
		next_cycle();
		touch_ready = 1'b0;
		rnd = $random(seed);
		gap = 5 + int'(rnd[4:0]);
		for (k = 1; k < 44; k++) begin
			touch_ready = (k == gap);
			next_cycle();
		end
		touch_ready = 1'b0;
		// Window stays put until the next end of frame
		check_eq("base_read_addr", 32'(base_read_addr), exp_base);
		if (west)
			m_img = (m_img == m_imgs - 1) ? 0 : m_img + 1;
		else
			m_img = (m_img == 0) ? m_imgs - 1 : m_img - 1;
		end_frame_and_compare();
		// Repeat inside the lockout must not have moved it again
		repeat (64) next_cycle();
		end_frame_and_compare();
	endtask

	// Code and position bits without touches
	task automatic gesture_byte_sweep();
		int         k;
		logic [7:0] raw;
		logic [7:0] want;
		for (k = 0; k < 200; k++) begin
			rnd = $random(seed);
			raw = rnd[31] ? known_raw[int'(rnd[10:8]) % 6] : rnd[7:0];
			touch_gesture = raw_gesture_e'(raw);
			touch_x = rnd[21:12];
			touch_y = rnd[30:22];
			want = {1'b0, packed_code(raw), touch_x[9:8], touch_y[8], 1'b0};
			next_cycle();
			check_eq("gesture_info", 32'(gesture_info), 32'(want));
		end
	endtask

	// Held bit rises within 3 cycles and is HOLD_WIDTH wide
	task automatic touch_hold();
		int k;
		int high;
		bit seen;
		touch_gesture = raw_up;
		touch_ready = 1'b1;
		seen = 1'b0;
		for (k = 1; k <= 3 && !seen; k++) begin
			next_cycle();
			touch_ready = 1'b0;
			seen = gesture_info[7];
		end
		assert (seen) else begin
			errors = errors + 1;
			$display("Touch-held bit did not rise within 3 cycles of the touch");
		end
		high = seen ? 1 : 0;
		while (seen && gesture_info[7] && high < 40) begin
			next_cycle();
			if (gesture_info[7])
				high = high + 1;
		end
		check_eq("touch-held width", high, HOLD_WIDTH);
		check_eq("gesture_info[6:0]", 32'(gesture_info[6:0]),
			32'({3'd1, touch_x[9:8], touch_y[8], 1'b0}));
		repeat (70) next_cycle();
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		seed = 32'h14a2;
		errors = 0;
		iRSTN = 1'b0;
		pixel_strobe = 1'b0;
		new_frame = 1'b0;
		end_frame = 1'b0;
		touch_ready = 1'b0;
		touch_gesture = raw_gesture_e'(8'h00);
		touch_x = '0;
		touch_y = '0;
		m_img = 0;
		exp_base = 0;
		rnd = $random(seed);
		m_imgs = 1 + int'(rnd[1:0]);
		img_num = 8'(m_imgs);

		startup_sequence();
		early_swipe();
		load_slideshow();
		random_frames();
		repeat (8) begin
			rnd = $random(seed);
			swipe_with_repeat(rnd[0]);
		end
		gesture_byte_sweep();
		repeat (3) touch_hold();

		$display("Run finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* src.f */
hw/slideshow_pkg.sv
hw/reset_sequencer.sv
hw/gesture_pulse.sv
hw/touch_front_end.sv
hw/image_selector.sv
hw/frame_address_gen.sv
hw/slideshow_ctrl.sv
verif/slideshow_props.sv
verif/tb_slideshow.sv

/* Makefile */
SRCS := $(shell cat src.f)

.PHONY: run clean

obj_dir/Vtb_slideshow: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_slideshow -f src.f

run: obj_dir/Vtb_slideshow
	@out="$$(./obj_dir/Vtb_slideshow)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
